// ==== logic/cpuCtrl_consts.svh ====
`ifndef CPUCTRL_CONSTS_SVH
`define CPUCTRL_CONSTS_SVH

`define CC_OPCODE_W 6
`define CC_FUNCT_W 6
`define CC_STEP_W 2
`define CC_SEL_W 3

`define CC_OP_RTYPE 6'h00
`define CC_OP_SLTI 6'h0A
`define CC_FN_ADD 6'h20
`define CC_FN_SLL 6'h00
`define CC_FN_SLLV 6'h04
`define CC_FN_SLT 6'h2A

`define CC_STEPS_FETCH 3
`define CC_STEPS_ADD 3
`define CC_STEPS_SHIFT 3
`define CC_STEPS_SLT 2

`define CC_ALU_ADD 3'd1
`define CC_ALU_SLT 3'd7
`define CC_REGDST_RD 3'd2
`define CC_REGDST_SP 3'd4
`define CC_MEMTOREG_ALU 3'd6
`define CC_MEMTOREG_SHIFT 3'd2
`define CC_MEMTOREG_LT 3'd5
`define CC_SRCA_PC 3'd0
`define CC_SRCA_A 3'd2
`define CC_SRCA_CMP 3'd4
`define CC_SRCB_REG 3'd0
`define CC_SRCB_FOUR 3'd1
`define CC_SRCB_OFFS 3'd3
`define CC_SRCB_IMM 3'd4
`define CC_SR_LOAD 3'd1
`define CC_SR_SHL 3'd2
`define CC_SRIN_A 2'd1
`define CC_SRNUM_SHAMT 2'd1

`endif

// ==== logic/cpuCtrlPkg.sv ====
`default_nettype none

`include "cpuCtrl_consts.svh"

package cpuCtrlPkg;

    typedef enum logic [2:0] {
        ADD,
        SLL,
        SLLV,
        SLT,
        SLTI,
        NONE
    } instrClass_t;

    typedef enum logic [2:0] {
        RESET_HOLD,
        RESET_INIT,
        FETCH,
        EXEC_ADD,
        EXEC_SLL,
        EXEC_SLLV,
        EXEC_SLT,
        EXEC_SLTI
    } phase_t;

    typedef struct packed {
        phase_t                 phase;
        logic [`CC_STEP_W-1:0]  step;
    } seqPos_t;

    typedef struct packed {
        logic                   pcWrite;
        logic                   memRw;       // Shared read/write strobe.
        logic                   irWrite;
        logic                   regWrite;
        logic [`CC_SEL_W-1:0]   aluOp;
        logic [`CC_SEL_W-1:0]   iord;
        logic [`CC_SEL_W-1:0]   aluSrcA;
        logic [`CC_SEL_W-1:0]   aluSrcB;
        logic [`CC_SEL_W-1:0]   regDst;
        logic [`CC_SEL_W-1:0]   memToReg;
        logic [`CC_SEL_W-1:0]   pcSource;
        logic [`CC_SEL_W-1:0]   srControl;
        logic [1:0]             srInputSel;
        logic [1:0]             srNumSel;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module instrDecoder (
    input  wire logic [`CC_OPCODE_W-1:0] opcode,
    input  wire logic [`CC_FUNCT_W-1:0]  funct,
    output cpuCtrlPkg::instrClass_t      instrClass
);

    always_comb begin
        case (opcode)
            `CC_OP_RTYPE: begin
                case (funct)
                    `CC_FN_ADD: instrClass = cpuCtrlPkg::ADD;
                    `CC_FN_SLL: instrClass = cpuCtrlPkg::SLL;
                    `CC_FN_SLLV: instrClass = cpuCtrlPkg::SLLV;
                    `CC_FN_SLT: instrClass = cpuCtrlPkg::SLT;
                    default: instrClass = cpuCtrlPkg::NONE;
                endcase
            end
            `CC_OP_SLTI: begin
                instrClass = cpuCtrlPkg::SLTI;   // Funct is don't-care.
            end
            default: begin
                instrClass = cpuCtrlPkg::NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/microSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module microSequencer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire cpuCtrlPkg::instrClass_t instrClass,
    output cpuCtrlPkg::seqPos_t          pos
);

    localparam logic [`CC_STEP_W-1:0] LAST_FETCH = `CC_STEPS_FETCH - 1;
    localparam logic [`CC_STEP_W-1:0] LAST_ADD = `CC_STEPS_ADD - 1;
    localparam logic [`CC_STEP_W-1:0] LAST_SHIFT = `CC_STEPS_SHIFT - 1;
    localparam logic [`CC_STEP_W-1:0] LAST_SLT = `CC_STEPS_SLT - 1;

    logic                  inReset;
    logic [`CC_STEP_W-1:0] lastStep;
    cpuCtrlPkg::seqPos_t   nextPos;

    assign inReset = (pos.phase == cpuCtrlPkg::RESET_HOLD) ||
                     (pos.phase == cpuCtrlPkg::RESET_INIT);

    always_comb begin
        case (pos.phase)
            cpuCtrlPkg::EXEC_ADD: lastStep = LAST_ADD;
            cpuCtrlPkg::EXEC_SLL, cpuCtrlPkg::EXEC_SLLV: lastStep = LAST_SHIFT;
            cpuCtrlPkg::EXEC_SLT, cpuCtrlPkg::EXEC_SLTI: lastStep = LAST_SLT;
            default: lastStep = LAST_FETCH;
        endcase
    end

    always_comb begin
        nextPos.phase = pos.phase;
        nextPos.step = pos.step + 1'b1;
        if (inReset) begin
            nextPos.phase = cpuCtrlPkg::FETCH;
            nextPos.step = '0;
        end else if (pos.step == lastStep) begin
            nextPos.step = '0;
            if (pos.phase == cpuCtrlPkg::FETCH) begin
                case (instrClass)   // Dispatch on the fetched instruction.
                    cpuCtrlPkg::ADD: nextPos.phase = cpuCtrlPkg::EXEC_ADD;
                    cpuCtrlPkg::SLL: nextPos.phase = cpuCtrlPkg::EXEC_SLL;
                    cpuCtrlPkg::SLLV: nextPos.phase = cpuCtrlPkg::EXEC_SLLV;
                    cpuCtrlPkg::SLT: nextPos.phase = cpuCtrlPkg::EXEC_SLT;
                    cpuCtrlPkg::SLTI: nextPos.phase = cpuCtrlPkg::EXEC_SLTI;
                    default: nextPos.phase = cpuCtrlPkg::FETCH;  // Refetch.
                endcase
            end else begin
                nextPos.phase = cpuCtrlPkg::FETCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Hold once, then keep initialising the stack pointer.
            if (inReset) begin
                pos.phase <= cpuCtrlPkg::RESET_INIT;
            end else begin
                pos.phase <= cpuCtrlPkg::RESET_HOLD;
            end
            pos.step <= '0;
        end else begin
            pos <= nextPos;
        end
    end

endmodule

`default_nettype wire

// ==== logic/controlStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module controlStore (
    input  wire cpuCtrlPkg::seqPos_t pos,
    output cpuCtrlPkg::ctrlWord_t    ctrl,
    output logic                     rstOut
);

    always_comb begin
        ctrl = '0;
        rstOut = 1'b0;
        case (pos.phase)
            cpuCtrlPkg::RESET_HOLD: begin
                rstOut = 1'b1;
            end
            cpuCtrlPkg::RESET_INIT: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = `CC_REGDST_SP;   // Stack pointer init.
                rstOut = 1'b1;
            end
            cpuCtrlPkg::FETCH: begin
                case (pos.step)
                    2'd1: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.irWrite = 1'b1;
                        ctrl.aluOp = `CC_ALU_ADD;
                        ctrl.aluSrcA = `CC_SRCA_PC;
                        ctrl.aluSrcB = `CC_SRCB_FOUR;   // PC + 4.
                    end
                    2'd2: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.irWrite = 1'b1;
                        ctrl.aluOp = `CC_ALU_ADD;
                        ctrl.aluSrcA = `CC_SRCA_PC;
                        ctrl.aluSrcB = `CC_SRCB_OFFS;
                    end
                    default: begin
                    end
                endcase
            end
            cpuCtrlPkg::EXEC_ADD: begin
                ctrl.aluOp = `CC_ALU_ADD;
                ctrl.aluSrcA = `CC_SRCA_A;
                case (pos.step)
                    2'd1, 2'd2: begin
                        ctrl.regWrite = 1'b1;   // Write back to rd.
                        ctrl.regDst = `CC_REGDST_RD;
                        ctrl.memToReg = `CC_MEMTOREG_ALU;
                    end
                    default: begin
                    end
                endcase
            end
            cpuCtrlPkg::EXEC_SLL, cpuCtrlPkg::EXEC_SLLV: begin
                case (pos.step)
                    2'd0: begin
                        ctrl.srInputSel = `CC_SRIN_A;
                        ctrl.srControl = `CC_SR_LOAD;
                    end
                    2'd1: begin
                        ctrl.srControl = `CC_SR_SHL;
                        if (pos.phase == cpuCtrlPkg::EXEC_SLL) begin
                            ctrl.srNumSel = `CC_SRNUM_SHAMT;   // Immediate shift amount.
                        end
                    end
                    2'd2: begin
                        // Write enable stays low here.
                        ctrl.regDst = `CC_REGDST_SP;
                        ctrl.memToReg = `CC_MEMTOREG_SHIFT;
                    end
                    default: begin
                    end
                endcase
            end
            cpuCtrlPkg::EXEC_SLT, cpuCtrlPkg::EXEC_SLTI: begin
                case (pos.step)
                    2'd0: begin
                        ctrl.aluOp = `CC_ALU_SLT;
                        ctrl.aluSrcA = `CC_SRCA_CMP;
                        if (pos.phase == cpuCtrlPkg::EXEC_SLTI) begin
                            ctrl.aluSrcB = `CC_SRCB_IMM;
                        end else begin
                            ctrl.aluSrcB = `CC_SRCB_REG;
                        end
                    end
                    2'd1: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.memToReg = `CC_MEMTOREG_LT;   // Less-than flag.
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module controlUnit (
    input  wire logic [`CC_OPCODE_W-1:0] opcode,
    input  wire logic [`CC_FUNCT_W-1:0]  funct,
    input  wire logic                    clk,
    input  wire logic                    rst,
    output cpuCtrlPkg::ctrlWord_t        ctrl,
    output logic                         rstOut
);

    cpuCtrlPkg::instrClass_t instrClass;
    cpuCtrlPkg::seqPos_t     pos;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    microSequencer sequencer (
        .clk        (clk),
        .rst        (rst),
        .instrClass (instrClass),
        .pos        (pos)
    );

    controlStore store (
        .pos    (pos),
        .ctrl   (ctrl),
        .rstOut (rstOut)
    );

endmodule

`default_nettype wire

// ==== bench/controlUnit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitAssert (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire cpuCtrlPkg::ctrlWord_t ctrl,
    input wire logic                  rstOut
);

    int failCount = 0;

    pcRegWriteExclusive: assert property (@(posedge clk) !(ctrl.pcWrite && ctrl.regWrite))
        else begin
            failCount++;
            $error("pcWrite and regWrite are high in the same cycle");
        end

    noPcWriteInReset: assert property (@(posedge clk) rstOut |-> !ctrl.pcWrite)
        else begin
            failCount++;
            $error("pcWrite is high while rstOut is high");
        end

    // Each fetch ends in an idle word within the longest sequence.
    fetchReturns: assert property (@(posedge clk) disable iff (rst)
            ctrl.irWrite |-> ##[1:8] (ctrl == '0))
        else begin
            failCount++;
            $error("no return to fetch step 0 after an instruction fetch");
        end

endmodule

bind controlUnit controlUnitAssert checks (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .rstOut (rstOut)
);

`default_nettype wire

// ==== bench/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module controlUnitTb;

    localparam int NUM_CYCLES = 4000;
    localparam int FETCH_TIMEOUT = 16;

    logic                        clk = 1'b0;
    logic                        rst;
    logic [`CC_OPCODE_W-1:0]     opcode;
    logic [`CC_FUNCT_W-1:0]      funct;
    cpuCtrlPkg::ctrlWord_t       ctrl;
    logic                        rstOut;

    cpuCtrlPkg::phase_t          mPhase;
    logic [`CC_STEP_W-1:0]       mStep;
    int                          execStarts [8];
    int                          refetches = 0;
    int                          midExecResets = 0;

    controlUnit UUT (
        .opcode (opcode),
        .funct  (funct),
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl),
        .rstOut (rstOut)
    );

    always #50 clk = ~clk;

    task automatic failNow();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkCtrl(input cpuCtrlPkg::ctrlWord_t actual,
                             input cpuCtrlPkg::ctrlWord_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns ctrl: got %h, expected %h (%s step %0d)",
                     $time, actual, expected, mPhase.name(), mStep);
            failNow();
        end
    endtask

    task automatic checkRstOut(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns rstOut: got %b, expected %b (%s step %0d)",
                     $time, actual, expected, mPhase.name(), mStep);
            failNow();
        end
    endtask

    function automatic int stepCount(input cpuCtrlPkg::phase_t ph);
        case (ph)
            cpuCtrlPkg::EXEC_ADD: return `CC_STEPS_ADD;
            cpuCtrlPkg::EXEC_SLL, cpuCtrlPkg::EXEC_SLLV: return `CC_STEPS_SHIFT;
            cpuCtrlPkg::EXEC_SLT, cpuCtrlPkg::EXEC_SLTI: return `CC_STEPS_SLT;
            default: return `CC_STEPS_FETCH;
        endcase
    endfunction

    // FETCH stands for an unsupported code.
    function automatic cpuCtrlPkg::phase_t dispatchPhase(input logic [5:0] op,
                                                         input logic [5:0] fn);
        if (op == `CC_OP_SLTI) return cpuCtrlPkg::EXEC_SLTI;
        if (op != `CC_OP_RTYPE) return cpuCtrlPkg::FETCH;
        case (fn)
            `CC_FN_ADD: return cpuCtrlPkg::EXEC_ADD;
            `CC_FN_SLL: return cpuCtrlPkg::EXEC_SLL;
            `CC_FN_SLLV: return cpuCtrlPkg::EXEC_SLLV;
            `CC_FN_SLT: return cpuCtrlPkg::EXEC_SLT;
            default: return cpuCtrlPkg::FETCH;
        endcase
    endfunction

    function automatic cpuCtrlPkg::ctrlWord_t expectedCtrl(input cpuCtrlPkg::phase_t ph,
                                                           input logic [1:0] st);
        cpuCtrlPkg::ctrlWord_t w;
        w = '0;
        if (ph == cpuCtrlPkg::RESET_INIT) begin
            w.regWrite = 1'b1;
            w.regDst = `CC_REGDST_SP;
        end else if (ph == cpuCtrlPkg::FETCH && st != 2'd0) begin
            w.pcWrite = 1'b1;
            w.irWrite = 1'b1;
            w.aluOp = `CC_ALU_ADD;
            w.aluSrcA = `CC_SRCA_PC;
            w.aluSrcB = (st == 2'd1) ? `CC_SRCB_FOUR : `CC_SRCB_OFFS;
        end else if (ph == cpuCtrlPkg::EXEC_ADD) begin
            w.aluOp = `CC_ALU_ADD;
            w.aluSrcA = `CC_SRCA_A;
            w.regWrite = (st != 2'd0);
            w.regDst = (st != 2'd0) ? `CC_REGDST_RD : 3'd0;
            w.memToReg = (st != 2'd0) ? `CC_MEMTOREG_ALU : 3'd0;
        end else if (ph == cpuCtrlPkg::EXEC_SLL || ph == cpuCtrlPkg::EXEC_SLLV) begin
            if (st == 2'd0) begin
                w.srInputSel = `CC_SRIN_A;
                w.srControl = `CC_SR_LOAD;
            end else if (st == 2'd1) begin
                w.srControl = `CC_SR_SHL;
                w.srNumSel = (ph == cpuCtrlPkg::EXEC_SLL) ? `CC_SRNUM_SHAMT : 2'd0;
            end else begin
                w.regDst = `CC_REGDST_SP;   // No write enable here.
                w.memToReg = `CC_MEMTOREG_SHIFT;
            end
        end else if (ph == cpuCtrlPkg::EXEC_SLT || ph == cpuCtrlPkg::EXEC_SLTI) begin
            if (st == 2'd0) begin
                w.aluOp = `CC_ALU_SLT;
                w.aluSrcA = `CC_SRCA_CMP;
                w.aluSrcB = (ph == cpuCtrlPkg::EXEC_SLTI) ? `CC_SRCB_IMM : `CC_SRCB_REG;
            end else begin
                w.regWrite = 1'b1;
                w.memToReg = `CC_MEMTOREG_LT;
            end
        end
        return w;
    endfunction

    task automatic advanceModel(input logic rstVal, input logic [5:0] op,
                                input logic [5:0] fn);
        cpuCtrlPkg::phase_t nextPh;
        logic inReset;
        inReset = (mPhase == cpuCtrlPkg::RESET_HOLD) || (mPhase == cpuCtrlPkg::RESET_INIT);
        if (rstVal) begin
            if (!inReset && mPhase != cpuCtrlPkg::FETCH) midExecResets++;
            mPhase = inReset ? cpuCtrlPkg::RESET_INIT : cpuCtrlPkg::RESET_HOLD;
            mStep = '0;
        end else if (inReset) begin
            mPhase = cpuCtrlPkg::FETCH;
            mStep = '0;
        end else if (int'(mStep) == stepCount(mPhase) - 1) begin
            nextPh = cpuCtrlPkg::FETCH;
            if (mPhase == cpuCtrlPkg::FETCH) begin
                nextPh = dispatchPhase(op, fn);
                if (nextPh == cpuCtrlPkg::FETCH) refetches++;
                else execStarts[int'(nextPh)]++;
            end
            mPhase = nextPh;
            mStep = '0;
        end else begin
            mStep = mStep + 1'b1;
        end
    endtask

    task automatic pickInstr(output logic [5:0] op, output logic [5:0] fn);
        int kind;
        op = $urandom_range(0, 63);
        fn = $urandom_range(0, 63);
        if ($urandom_range(0, 9) < 8) begin
            kind = $urandom_range(0, 4);
            op = (kind == 4) ? `CC_OP_SLTI : `CC_OP_RTYPE;   // SLTI keeps a random funct.
            case (kind)
                0: fn = `CC_FN_ADD;
                1: fn = `CC_FN_SLL;
                2: fn = `CC_FN_SLLV;
                3: fn = `CC_FN_SLT;
                default: begin
                end
            endcase
        end
    endtask

    task automatic runCycle(input logic rstVal, input logic [5:0] op, input logic [5:0] fn);
        @(negedge clk);
        rst = rstVal;
        opcode = op;
        funct = fn;
        @(posedge clk);
        advanceModel(rstVal, op, fn);
        #1;
        checkCtrl(ctrl, expectedCtrl(mPhase, mStep));
        checkRstOut(rstOut, mPhase == cpuCtrlPkg::RESET_HOLD || mPhase == cpuCtrlPkg::RESET_INIT);
        if (UUT.checks.failCount != 0) begin
            $display("A bound assertion on the control unit failed.");
            failNow();
        end
    endtask

    task automatic waitForFetch(input int limit);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            #1;
            seen = (ctrl.irWrite === 1'b1) && (ctrl.aluSrcB === `CC_SRCB_FOUR);
            n++;
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for an instruction fetch.", limit);
            failNow();
        end
    endtask

    initial begin
        logic [5:0] op;
        logic [5:0] fn;
        logic rstVal;
        logic covered;
        rst = 1'b1;
        opcode = '0;
        funct = '0;
        void'($urandom(32'h7156));
        foreach (execStarts[k]) execStarts[k] = 0;

        // Power-up phase is unknown, so the model starts at the first fetch.
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        waitForFetch(FETCH_TIMEOUT);
        mPhase = cpuCtrlPkg::FETCH;
        mStep = 2'd1;

        for (int i = 0; i < 5; i++) runCycle(1'b1, 6'd0, 6'd0);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            rstVal = ($urandom_range(0, 99) < 2);
            pickInstr(op, fn);
            runCycle(rstVal, op, fn);
        end

        covered = (refetches > 0) && (midExecResets > 0);
        for (int p = int'(cpuCtrlPkg::EXEC_ADD); p <= int'(cpuCtrlPkg::EXEC_SLTI); p++) begin
            if (execStarts[p] == 0) covered = 1'b0;
        end
        if (covered) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Random run missed an instruction class, a refetch or a mid-exec reset.");
            failNow();
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/cpuCtrlPkg.sv
logic/instrDecoder.sv
logic/microSequencer.sv
logic/controlStore.sv
logic/controlUnit.sv
bench/controlUnit_assert.sv
bench/controlUnitTb.sv
